// File: flist.f
+incdir+.
gat_pkg.sv
gat_spmm.sv
gat_dmvm.sv
gat_coef_fifo.sv
gat_conv1.sv
tb_gat_conv1.sv

// File: Makefile
TOP = tb_gat_conv1

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: tb_gat_conv1.sv
`default_nettype none

`include "gat_params.svh"

module tb_gat_conv1 import gat_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;

  logic                  clk;
  logic                  rst_n;
  h_entry_t              h_entry_i;
  logic                  h_vld_i;
  logic                  h_rdy_o;
  logic                  wgt_we_i;
  logic [`GAT_COL_W-1:0] wgt_addr_i;
  wgt_row_t              wgt_row_i;
  att_vec_t              att_i;
  coef_t                 coef_o;
  logic                  coef_empty_o;
  logic                  coef_rd_i;

  integer   seed;
  wgt_row_t wgt_model [`GAT_NUM_FEAT_IN];
  int       tgt_model;
  coef_t    exp_q [$];
  logic     rd_en;
  int       leaky_cnt;

  gat_conv1 dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    abort_run();
  endtask

  task automatic check_coef(input coef_t got, input coef_t exp);
    if (got !== exp) begin
      $display("FAIL coef_o got 0x%h expected 0x%h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  task automatic load_weights();
    for (int i = 0; i < `GAT_NUM_FEAT_IN; i++) begin
      wgt_model[i] = wgt_row_t'(next_rand());
      wgt_we_i     = 1'b1;
      wgt_addr_i   = i[`GAT_COL_W-1:0];
      wgt_row_i    = wgt_model[i];
      @(negedge clk);
    end
    wgt_we_i = 1'b0;
  endtask

  // Large negative neighbour weights push most scores below zero
  task automatic set_att(input logic neg_neigh);
    logic [31:0] r;
    r = next_rand();
    att_i.a_self = r;
    r = next_rand();
    att_i.a_neigh = r;
    if (neg_neigh) begin
      for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
        att_i.a_neigh[f] = {4'h8, r[4*f +: 4]};
      end
    end
  endtask

  task automatic send_entry(input h_entry_t e);
    int waited = 0;
    while (!h_rdy_o) begin
      if (waited == TIMEOUT) report_error("h_rdy_o stayed low while an entry waited");
      @(negedge clk);
      waited++;
    end
    h_entry_i = e;
    h_vld_i   = 1'b1;
    @(negedge clk);
    h_vld_i   = 1'b0;
  endtask

  // Sends one row and queues the coefficient the model expects for it
  task automatic send_row(input int len, input logic tgt);
    h_entry_t    e;
    logic [31:0] r;
    int          acc [`GAT_NUM_FEAT_OUT] = '{default: 0};
    wh_elem_t    wh;
    int          s_self = 0;
    int          raw = 0;
    for (int k = 0; k < len; k++) begin
      r      = next_rand();
      e.val  = r[7:0];
      e.col  = r[11:8];
      e.last = (k == len - 1);
      e.tgt  = tgt;
      for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
        acc[f] += int'(e.val) * int'(wgt_model[e.col][f]);
      end
      send_entry(e);
    end
    for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
      wh = wh_elem_t'(acc[f] >>> `GAT_WH_SHIFT);
      s_self += int'(att_i.a_self[f]) * int'(wh);
      raw    += int'(att_i.a_neigh[f]) * int'(wh);
    end
    if (tgt) tgt_model = s_self;
    raw = raw + tgt_model;
    if (raw < 0) begin
      raw = raw >>> `GAT_LEAKY_SHIFT;
      leaky_cnt++;
    end
    exp_q.push_back(coef_t'(raw >>> `GAT_COEF_SHIFT));
  endtask

  task automatic run_subgraph();
    int rows;
    rows = 1 + int'(next_rand() % 5);
    for (int i = 0; i < rows; i++) begin
      send_row(1 + int'(next_rand() % 6), i == 0);
    end
  endtask

  task automatic wait_drain();
    int waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == TIMEOUT) report_error("expected coefficients never left the FIFO");
      @(negedge clk);
      waited++;
    end
  endtask

  // Reader pops the head whenever it is valid and reading is on
  initial begin
    coef_rd_i = 1'b0;
    forever begin
      @(negedge clk);
      if (rd_en && !coef_empty_o) begin
        if (exp_q.size() == 0) report_error("FIFO showed a coefficient nobody expected");
        check_coef(coef_o, exp_q.pop_front());
        coef_rd_i = 1'b1;
      end else begin
        coef_rd_i = 1'b0;
      end
    end
  end

  initial begin
    int waited;
    seed       = 32'hcbf3_4c9f;
    rst_n      = 1'b0;
    h_entry_i  = '0;
    h_vld_i    = 1'b0;
    wgt_we_i   = 1'b0;
    wgt_addr_i = '0;
    wgt_row_i  = '0;
    att_i      = '0;
    rd_en      = 1'b0;
    leaky_cnt  = 0;
    tgt_model  = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("h_rdy_o", h_rdy_o, 1'b1);
    check_bit("coef_empty_o", coef_empty_o, 1'b1);

    rd_en = 1'b1;
    load_weights();
    set_att(1'b0);
    for (int sg = 0; sg < 16; sg++) begin
      // Fresh weights and attention, the next target row replaces the stored score
      if (sg % 4 == 3) begin
        wait_drain();
        load_weights();
        set_att(sg == 7);
      end
      run_subgraph();
    end
    wait_drain();

    // Reader stopped until the input stalls on a full queue
    rd_en  = 1'b0;
    waited = 0;
    while (h_rdy_o) begin
      if (waited == TIMEOUT) report_error("h_rdy_o never dropped with the reader stopped");
      send_row(1, waited == 0);
      waited++;
    end
    if (exp_q.size() > `GAT_COEF_DEPTH) begin
      report_error("more rows accepted than the FIFO can hold");
    end

    // Entries offered while the queue is full must be refused
    h_entry_i     = '0;
    h_entry_i.val = 8'sh40;
    h_vld_i       = 1'b1;
    for (int i = 0; i < 4; i++) begin
      check_bit("h_rdy_o", h_rdy_o, 1'b0);
      @(negedge clk);
    end
    h_vld_i = 1'b0;

    rd_en = 1'b1;
    wait_drain();
    @(negedge clk);
    check_bit("coef_empty_o", coef_empty_o, 1'b1);

    // A refused entry would have leaked into this row
    send_row(2, 1'b1);
    wait_drain();

    if (leaky_cnt == 0) begin
      report_error("no row ever had a negative raw score");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: gat_conv1.sv
`default_nettype none

`include "gat_params.svh"

module gat_conv1 import gat_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  h_entry_t              h_entry_i,
  input  logic                  h_vld_i,
  output logic                  h_rdy_o,
  input  logic                  wgt_we_i,
  input  logic [`GAT_COL_W-1:0] wgt_addr_i,
  input  wgt_row_t              wgt_row_i,
  input  att_vec_t              att_i,
  output coef_t                 coef_o,
  output logic                  coef_empty_o,
  input  logic                  coef_rd_i
);

  wh_t   wh_data;
  logic  wh_vld;
  coef_t coef_din;
  logic  coef_wr;

  gat_spmm u_spmm (
    .clk        (clk),
    .rst_n      (rst_n),
    .h_entry_i  (h_entry_i),
    .h_vld_i    (h_vld_i),
    .h_rdy_i    (h_rdy_o),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_row_i  (wgt_row_i),
    .wh_o       (wh_data),
    .wh_vld_o   (wh_vld)
  );

  gat_dmvm u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_i       (wh_data),
    .wh_vld_i   (wh_vld),
    .att_i      (att_i),
    .coef_o     (coef_din),
    .coef_vld_o (coef_wr)
  );

  // Free space in the queue throttles the input stream
  gat_coef_fifo u_coef_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .din_i      (coef_din),
    .wr_i       (coef_wr),
    .rd_i       (coef_rd_i),
    .dout_o     (coef_o),
    .empty_o    (coef_empty_o),
    .space_ok_o (h_rdy_o)
  );

endmodule

`default_nettype wire

// File: gat_coef_fifo.sv
`default_nettype none

`include "gat_params.svh"

module gat_coef_fifo import gat_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  coef_t din_i,
  input  logic  wr_i,
  input  logic  rd_i,
  output coef_t dout_o,
  output logic  empty_o,
  output logic  space_ok_o
);

  localparam int PTR_W = $clog2(`GAT_COEF_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  coef_t            mem [`GAT_COEF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full       = (count == CNT_W'(`GAT_COEF_DEPTH));
  assign empty_o    = (count == '0);
  assign space_ok_o = (CNT_W'(`GAT_COEF_DEPTH) - count) >= CNT_W'(`GAT_COEF_SPACE);
  assign do_wr      = wr_i && !full;
  assign do_rd      = rd_i && !empty_o;

  // Head is always visible
  assign dout_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_write_full : assert property (@(posedge clk) disable iff (!rst_n) wr_i |-> !full)
    else $error("gat_coef_fifo: write while full");

  a_no_read_empty : assert property (@(posedge clk) disable iff (!rst_n) rd_i |-> !empty_o)
    else $error("gat_coef_fifo: read while empty");

endmodule

`default_nettype wire

// File: gat_dmvm.sv
`default_nettype none

`include "gat_params.svh"

module gat_dmvm import gat_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  wh_t      wh_i,
  input  logic     wh_vld_i,
  input  att_vec_t att_i,
  output coef_t    coef_o,
  output logic     coef_vld_o
);

  logic signed [`GAT_SCORE_W-1:0] dot_self;
  logic signed [`GAT_SCORE_W-1:0] dot_neigh;
  logic signed [`GAT_SCORE_W-1:0] s1_self_q;
  logic signed [`GAT_SCORE_W-1:0] s1_neigh_q;
  logic                           s1_tgt_q;
  logic                           s1_vld;
  logic signed [`GAT_SCORE_W-1:0] tgt_score_q;
  logic signed [`GAT_SCORE_W-1:0] tgt_sel;
  logic signed [`GAT_SCORE_W-1:0] raw;
  logic signed [`GAT_SCORE_W-1:0] leaky;
  logic signed [`GAT_SCORE_W-1:0] scaled;

  // Both dot products against the incoming Wh
  always_comb begin
    dot_self  = '0;
    dot_neigh = '0;
    for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
      dot_self  = dot_self + att_i.a_self[f] * wh_i.feat[f];
      dot_neigh = dot_neigh + att_i.a_neigh[f] * wh_i.feat[f];
    end
  end

  // Stage 1
  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      s1_self_q  <= dot_self;
      s1_neigh_q <= dot_neigh;
      s1_tgt_q   <= wh_i.tgt;
    end
  end

  // A target row uses its own self score
  assign tgt_sel = s1_tgt_q ? s1_self_q : tgt_score_q;
  assign raw     = tgt_sel + s1_neigh_q;
  assign leaky   = raw[`GAT_SCORE_W-1] ? (raw >>> `GAT_LEAKY_SHIFT) : raw;
  assign scaled  = leaky >>> `GAT_COEF_SHIFT;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld      <= 1'b0;
      coef_vld_o  <= 1'b0;
      tgt_score_q <= '0;
    end else begin
      s1_vld     <= wh_vld_i;
      coef_vld_o <= s1_vld;
      if (s1_vld && s1_tgt_q) begin
        tgt_score_q <= s1_self_q;
      end
    end
  end

  // Stage 2, wraps to 8 bits
  always_ff @(posedge clk) begin
    if (s1_vld) begin
      coef_o <= scaled[`GAT_DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: gat_spmm.sv
`default_nettype none

`include "gat_params.svh"

module gat_spmm import gat_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  h_entry_t              h_entry_i,
  input  logic                  h_vld_i,
  input  logic                  h_rdy_i,
  input  logic                  wgt_we_i,
  input  logic [`GAT_COL_W-1:0] wgt_addr_i,
  input  wgt_row_t              wgt_row_i,
  output wh_t                   wh_o,
  output logic                  wh_vld_o
);

  localparam int PROD_W = 2 * `GAT_DATA_W;

  wgt_row_t                     wgt_mem [`GAT_NUM_FEAT_IN];
  wgt_row_t                     wgt_sel;
  logic signed [PROD_W-1:0]     prod    [`GAT_NUM_FEAT_OUT];
  logic signed [`GAT_ACC_W-1:0] acc_q   [`GAT_NUM_FEAT_OUT];
  logic signed [`GAT_ACC_W-1:0] acc_nxt [`GAT_NUM_FEAT_OUT];
  logic                         accept;
  logic                         row_end;
  logic                         in_row;
  logic                         row_tgt;

  assign accept  = h_vld_i && h_rdy_i;
  assign row_end = accept && h_entry_i.last;
  assign wgt_sel = wgt_mem[h_entry_i.col];

  // Weight array, loaded row by row between node rows
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GAT_NUM_FEAT_IN; i++) begin
        wgt_mem[i] <= '0;
      end
    end else if (wgt_we_i) begin
      wgt_mem[wgt_addr_i] <= wgt_row_i;
    end
  end

  // Scale the selected weight row by the entry value
  always_comb begin
    for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
      prod[f]    = h_entry_i.val * wgt_sel[f];
      acc_nxt[f] = acc_q[f] + prod[f];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
        acc_q[f] <= '0;
      end
      in_row   <= 1'b0;
      row_tgt  <= 1'b0;
      wh_vld_o <= 1'b0;
    end else begin
      wh_vld_o <= row_end;
      if (accept) begin
        in_row  <= !h_entry_i.last;
        row_tgt <= h_entry_i.last ? 1'b0 : (row_tgt || h_entry_i.tgt);
        for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
          acc_q[f] <= h_entry_i.last ? '0 : acc_nxt[f];
        end
      end
    end
  end

  // Wh takes bits 15:4 of the finished row sum
  always_ff @(posedge clk) begin
    if (row_end) begin
      for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
        wh_o.feat[f] <= acc_nxt[f][`GAT_WH_SHIFT +: `GAT_WH_W];
      end
      wh_o.tgt <= row_tgt || h_entry_i.tgt;
    end
  end

  // Weights must stay put while a row accumulates
  a_no_wgt_write_in_row : assert property (
    @(posedge clk) disable iff (!rst_n) !(wgt_we_i && in_row)
  ) else $error("gat_spmm: weight write while a row is in progress");

endmodule

`default_nettype wire

// File: gat_pkg.sv
`default_nettype none

`include "gat_params.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic signed [`GAT_WH_W-1:0]   wh_elem_t;

  // One sparse entry of the H stream
  typedef struct packed {
    data_t                 val;
    logic [`GAT_COL_W-1:0] col;
    logic                  last;
    logic                  tgt;
  } h_entry_t;

  typedef data_t [`GAT_NUM_FEAT_OUT-1:0] wgt_row_t;

  typedef struct packed {
    wh_elem_t [`GAT_NUM_FEAT_OUT-1:0] feat;
    logic                             tgt;
  } wh_t;

  // Self half first, neighbour half second
  typedef struct packed {
    data_t [`GAT_NUM_FEAT_OUT-1:0] a_self;
    data_t [`GAT_NUM_FEAT_OUT-1:0] a_neigh;
  } att_vec_t;

  typedef logic signed [`GAT_DATA_W-1:0] coef_t;

endpackage

`default_nettype wire

// File: gat_params.svh
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// Feature dimensions
`define GAT_NUM_FEAT_IN   16
`define GAT_NUM_FEAT_OUT  4

// Datapath widths
`define GAT_DATA_W        8
`define GAT_COL_W         4
`define GAT_ACC_W         20
`define GAT_WH_W          12
`define GAT_SCORE_W       24

// Fixed-point scaling
`define GAT_WH_SHIFT      4
`define GAT_COEF_SHIFT    6
`define GAT_LEAKY_SHIFT   3

// Coefficient queue
`define GAT_COEF_DEPTH    8
`define GAT_COEF_SPACE    4

`endif
